// File: filelist.f
logic/cpu_pkg.sv
logic/step_sequencer.sv
logic/reg_file.sv
logic/alu.sv
logic/wb_master.sv
logic/cpu_top.sv
sim/tb_cpu.sv

// File: logic/alu.sv
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [3:0]  alu_op,
  input  logic [15:0] a,
  input  logic [15:0] b,
  input  logic        flags_en,
  input  logic [2:0]  cond_code,
  output logic [15:0] result,
  output logic        cond_true
);

  logic [3:0]  flags;
  logic [3:0]  flags_next;
  logic [16:0] sum;
  logic [16:0] diff;
  logic        carry;
  logic        ovf;

  assign sum  = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} - {1'b0, b}; // Bit 16 is the borrow

  always_comb begin
    carry = 1'b0;
    ovf   = 1'b0;
    case (alu_op)
      OP_ADD: begin
        result = sum[15:0];
        carry  = sum[16];
        ovf    = (a[15] == b[15]) && (sum[15] != a[15]);
      end
      OP_SUB: begin
        result = diff[15:0];
        carry  = diff[16];
        ovf    = (a[15] != b[15]) && (diff[15] != a[15]);
      end
      OP_AND:  result = a & b;
      OP_OR:   result = a | b;
      OP_XOR:  result = a ^ b;
      default: result = b;
    endcase
  end

  always_comb begin
    flags_next         = 4'h0;
    flags_next[FLAG_Z] = (result == 16'h0000);
    flags_next[FLAG_C] = carry;
    flags_next[FLAG_N] = result[15];
    flags_next[FLAG_V] = ovf;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= 4'h0;
    end else if (flags_en) begin
      flags <= flags_next;
    end
  end

  // Even code tests set, odd code tests clear
  assign cond_true = flags[cond_code[2:1]] ^ cond_code[0];

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

  // Main opcodes
  localparam logic [3:0] OP_SYS = 4'd0;
  localparam logic [3:0] OP_LD  = 4'd1;
  localparam logic [3:0] OP_ST  = 4'd2;
  localparam logic [3:0] OP_ADD = 4'd3;
  localparam logic [3:0] OP_SUB = 4'd4;
  localparam logic [3:0] OP_AND = 4'd5;
  localparam logic [3:0] OP_OR  = 4'd6;
  localparam logic [3:0] OP_XOR = 4'd7;
  localparam logic [3:0] OP_JMP = 4'd12;
  localparam logic [3:0] OP_CMP = 4'd14;
  localparam logic [3:0] OP_BR  = 4'd15;

  // SYS sub-codes, taken from {imm, dst}
  localparam logic [3:0] SYS_NOP = 4'd0;
  localparam logic [3:0] SYS_OUT = 4'd2;
  localparam logic [3:0] SYS_HLT = 4'd15;

  localparam logic [2:0] REG_PC  = 3'd0;
  localparam logic [2:0] REG_TMP = 3'd7;

  localparam int FLAG_Z = 0;
  localparam int FLAG_C = 1;
  localparam int FLAG_N = 2;
  localparam int FLAG_V = 3;

  typedef struct packed {
    logic [3:0] op;
    logic       imm;
    logic [2:0] dst;
    logic       ind;
    logic [2:0] src;
    logic [3:0] off;
  } instr_fields_t;

  typedef struct packed {
    logic [3:0]  op;
    logic [11:0] target;
  } instr_target_t;

  // JMP reads the target view, all others the field view
  typedef union packed {
    instr_fields_t f;
    instr_target_t t;
  } instr_t;

endpackage

// File: logic/cpu_top.sv
`timescale 1ns/100ps

module cpu_top #(
  parameter int ADDR_W = 12
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [15:0]       wb_dat_i,
  input  logic              wb_ack,
  output logic              wb_cyc,
  output logic              wb_stb,
  output logic              wb_we,
  output logic [ADDR_W-1:0] wb_adr,
  output logic [15:0]       wb_dat_o,
  output logic [15:0]       out_data,
  output logic              out_valid,
  output logic              halted
);

  logic [2:0]  rd_a_sel;
  logic [2:0]  rd_b_sel;
  logic [2:0]  wr_sel;
  logic        wr_en;
  logic        pc_inc;
  logic        jump_en;
  logic [3:0]  alu_op;
  logic        flags_en;
  logic [2:0]  cond_code;
  logic        cond_true;
  logic        addr_load;
  logic        mem_rd;
  logic        mem_wr;
  logic        mem_done;
  logic [15:0] mem_data;
  logic [15:0] bus;
  logic [15:0] rd_a;
  logic [15:0] rd_b;
  logic [15:0] alu_result;

  step_sequencer u_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_b          (rd_b),
    .alu_result    (alu_result),
    .cond_true     (cond_true),
    .mem_data      (mem_data),
    .mem_done      (mem_done),
    .rd_a_sel      (rd_a_sel),
    .rd_b_sel      (rd_b_sel),
    .wr_sel        (wr_sel),
    .wr_en         (wr_en),
    .pc_inc        (pc_inc),
    .jump_en       (jump_en),
    .alu_op        (alu_op),
    .alu_b_sel_tmp (), // Already folded into rd_b_sel
    .flags_en      (flags_en),
    .cond_code     (cond_code),
    .addr_load     (addr_load),
    .mem_rd        (mem_rd),
    .mem_wr        (mem_wr),
    .bus           (bus),
    .out_data      (out_data),
    .out_valid     (out_valid),
    .halted        (halted)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_a_sel (rd_a_sel),
    .rd_b_sel (rd_b_sel),
    .wr_sel   (wr_sel),
    .wr_en    (wr_en),
    .pc_inc   (pc_inc),
    .jump_en  (jump_en),
    .wr_data  (bus),
    .rd_a     (rd_a),
    .rd_b     (rd_b)
  );

  alu u_alu (
    .clk       (clk),
    .rst_n     (rst_n),
    .alu_op    (alu_op),
    .a         (rd_a),
    .b         (rd_b),
    .flags_en  (flags_en),
    .cond_code (cond_code),
    .result    (alu_result),
    .cond_true (cond_true)
  );

  wb_master #(
    .ADDR_W (ADDR_W)
  ) u_wbm (
    .clk       (clk),
    .rst_n     (rst_n),
    .addr_load (addr_load),
    .bus       (bus),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .wb_dat_i  (wb_dat_i),
    .wb_ack    (wb_ack),
    .mem_data  (mem_data),
    .mem_done  (mem_done),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_o  (wb_dat_o)
  );

endmodule

// File: logic/reg_file.sv
`timescale 1ns/100ps

module reg_file import cpu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [2:0]  rd_a_sel,
  input  logic [2:0]  rd_b_sel,
  input  logic [2:0]  wr_sel,
  input  logic        wr_en,
  input  logic        pc_inc,
  input  logic        jump_en,
  input  logic [15:0] wr_data,
  output logic [15:0] rd_a,
  output logic [15:0] rd_b
);

  logic [15:0] pc;
  logic [15:0] gpr [1:7]; // r1..r6 plus temporary r7
  logic        pc_load;

  assign pc_load = jump_en | (wr_en & (wr_sel == REG_PC));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= 16'h0000;
    end else if (pc_load) begin
      pc <= wr_data;
    end else if (pc_inc) begin
      pc <= pc + 16'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && (wr_sel != REG_PC)) begin
      gpr[wr_sel] <= wr_data;
    end
  end

  always_comb begin
    rd_a = pc;
    if (rd_a_sel != REG_PC) begin
      rd_a = gpr[rd_a_sel];
    end
  end

  always_comb begin
    rd_b = pc;
    if (rd_b_sel != REG_PC) begin
      rd_b = gpr[rd_b_sel];
    end
  end

  a_pc_one_src: assert property (@(posedge clk) disable iff (!rst_n)
    !(pc_inc && pc_load));

endmodule

// File: logic/step_sequencer.sv
`timescale 1ns/100ps

module step_sequencer import cpu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] rd_b,
  input  logic [15:0] alu_result,
  input  logic        cond_true,
  input  logic [15:0] mem_data,
  input  logic        mem_done,
  output logic [2:0]  rd_a_sel,
  output logic [2:0]  rd_b_sel,
  output logic [2:0]  wr_sel,
  output logic        wr_en,
  output logic        pc_inc,
  output logic        jump_en,
  output logic [3:0]  alu_op,
  output logic        alu_b_sel_tmp,
  output logic        flags_en,
  output logic [2:0]  cond_code,
  output logic        addr_load,
  output logic        mem_rd,
  output logic        mem_wr,
  output logic [15:0] bus,
  output logic [15:0] out_data,
  output logic        out_valid,
  output logic        halted
);

  logic [2:0]  step;
  instr_t      ir;
  logic [2:0]  b_sel;
  logic        src_reg;
  logic        src_mem;
  logic        src_alu;
  logic        src_imm;
  logic        alu_step;
  logic        last_step;
  logic        ir_load;
  logic        halt_set;
  logic        out_en;
  logic        advance;
  logic [3:0]  sys_code;
  logic [15:0] imm_val;

  assign sys_code  = {ir.f.imm, ir.f.dst};
  assign rd_a_sel  = ir.f.dst;
  assign cond_code = ir.f.dst;
  assign rd_b_sel  = alu_b_sel_tmp ? REG_TMP : b_sel;
  assign alu_op    = (ir.f.op == OP_CMP) ? OP_SUB : ir.f.op; // CMP is a flags-only SUB

  // JMP carries 12 bits, everything else a zero-extended byte
  assign imm_val = (ir.t.op == OP_JMP) ? {4'h0, ir.t.target}
                                       : {8'h00, ir.f.ind, ir.f.src, ir.f.off};

  always_comb begin
    b_sel         = ir.f.src;
    wr_sel        = ir.f.dst;
    wr_en         = 1'b0;
    pc_inc        = 1'b0;
    jump_en       = 1'b0;
    alu_b_sel_tmp = 1'b0;
    flags_en      = 1'b0;
    addr_load     = 1'b0;
    mem_rd        = 1'b0;
    mem_wr        = 1'b0;
    src_reg       = 1'b0;
    src_mem       = 1'b0;
    src_alu       = 1'b0;
    src_imm       = 1'b0;
    alu_step      = 1'b0;
    last_step     = 1'b0;
    ir_load       = 1'b0;
    halt_set      = 1'b0;
    out_en        = 1'b0;
    if (!halted) begin
      case (step)
        3'd0: begin
          b_sel     = REG_PC; // PC to address register
          src_reg   = 1'b1;
          addr_load = 1'b1;
        end
        3'd1: begin
          mem_rd  = 1'b1;
          src_mem = 1'b1;
          ir_load = mem_done;
          pc_inc  = mem_done;
        end
        default: begin
          case (ir.f.op)
            OP_SYS: begin
              case (sys_code)
                SYS_NOP: last_step = 1'b1;
                SYS_OUT: begin
                  if (!ir.f.ind) begin
                    src_reg   = 1'b1;
                    out_en    = 1'b1;
                    last_step = 1'b1;
                  end else if (step == 3'd2) begin
                    src_reg   = 1'b1;
                    addr_load = 1'b1;
                  end else begin
                    mem_rd    = 1'b1;
                    src_mem   = 1'b1;
                    out_en    = 1'b1;
                    last_step = 1'b1;
                  end
                end
                SYS_HLT: begin
                  halt_set  = 1'b1;
                  last_step = 1'b1;
                end
                default: last_step = 1'b1;
              endcase
            end
            OP_LD: begin
              if (ir.f.imm) begin
                src_imm   = 1'b1;
                wr_en     = 1'b1;
                last_step = 1'b1;
              end else if (!ir.f.ind) begin
                src_reg   = 1'b1;
                wr_en     = 1'b1;
                last_step = 1'b1;
              end else if (step == 3'd2) begin
                src_reg   = 1'b1;
                addr_load = 1'b1;
              end else begin
                mem_rd    = 1'b1;
                src_mem   = 1'b1;
                wr_en     = mem_done;
                last_step = 1'b1;
              end
            end
            OP_ST: begin
              src_reg = 1'b1;
              if (step == 3'd2) begin
                b_sel     = ir.f.dst; // Address comes from dst
                addr_load = 1'b1;
              end else begin
                mem_wr    = 1'b1;
                last_step = 1'b1;
              end
            end
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_CMP: begin
              if (ir.f.imm) begin
                if (step == 3'd2) begin
                  src_imm = 1'b1;
                  wr_sel  = REG_TMP;
                  wr_en   = 1'b1;
                end else begin
                  alu_step = 1'b1;
                end
              end else if (ir.f.ind) begin
                if (step == 3'd2) begin
                  src_reg   = 1'b1;
                  addr_load = 1'b1;
                end else if (step == 3'd3) begin
                  mem_rd  = 1'b1;
                  src_mem = 1'b1;
                  wr_sel  = REG_TMP;
                  wr_en   = mem_done;
                end else begin
                  alu_step = 1'b1;
                end
              end else begin
                alu_step = 1'b1;
              end
            end
            OP_JMP: begin
              src_imm   = 1'b1;
              jump_en   = 1'b1;
              last_step = 1'b1;
            end
            OP_BR: begin
              if (!cond_true) begin
                last_step = 1'b1; // Not taken
              end else if (ir.f.imm) begin
                src_imm   = 1'b1;
                jump_en   = 1'b1;
                last_step = 1'b1;
              end else if (!ir.f.ind) begin
                src_reg   = 1'b1;
                jump_en   = 1'b1;
                last_step = 1'b1;
              end else if (step == 3'd2) begin
                src_reg   = 1'b1;
                addr_load = 1'b1;
              end else begin
                mem_rd    = 1'b1;
                src_mem   = 1'b1;
                jump_en   = mem_done;
                last_step = 1'b1;
              end
            end
            default: last_step = 1'b1; // Unused opcodes act as NOP
          endcase

          if (alu_step) begin
            alu_b_sel_tmp = ir.f.imm | ir.f.ind; // Operand parked in r7
            src_alu       = 1'b1;
            flags_en      = 1'b1;
            wr_en         = (ir.f.op != OP_CMP);
            last_step     = 1'b1;
          end
        end
      endcase
    end
  end

  assign bus = ({16{src_reg}} & rd_b)
             | ({16{src_mem}} & mem_data)
             | ({16{src_alu}} & alu_result)
             | ({16{src_imm}} & imm_val);

  assign out_data  = bus;
  assign out_valid = out_en & (~mem_rd | mem_done);

  // Memory steps hold the counter until the slave acks
  assign advance = ~halted & (~(mem_rd | mem_wr) | mem_done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step   <= 3'd0;
      ir     <= '0;
      halted <= 1'b0;
    end else begin
      if (advance) begin
        step <= last_step ? 3'd0 : step + 3'd1;
      end
      if (ir_load) begin
        ir <= bus;
      end
      if (halt_set) begin
        halted <= 1'b1;
      end
    end
  end

  a_bus_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({src_reg, src_mem, src_alu, src_imm}));

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_rd && mem_wr));

endmodule

// File: logic/wb_master.sv
`timescale 1ns/100ps

module wb_master #(
  parameter int ADDR_W = 12
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              addr_load,
  input  logic [15:0]       bus,
  input  logic              mem_rd,
  input  logic              mem_wr,
  input  logic [15:0]       wb_dat_i,
  input  logic              wb_ack,
  output logic [15:0]       mem_data,
  output logic              mem_done,
  output logic              wb_cyc,
  output logic              wb_stb,
  output logic              wb_we,
  output logic [ADDR_W-1:0] wb_adr,
  output logic [15:0]       wb_dat_o
);

  logic recover; // Idle cycle after each ack

  always_ff @(posedge clk) begin
    if (addr_load) begin
      wb_adr <= bus[ADDR_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      recover <= 1'b0;
    end else begin
      recover <= wb_cyc & wb_ack;
    end
  end

  // Cycle opens in the first cycle of the memory step
  assign wb_cyc   = (mem_rd | mem_wr) & ~recover;
  assign wb_stb   = wb_cyc;
  assign wb_we    = mem_wr;
  assign wb_dat_o = bus;
  assign mem_data = wb_dat_i;
  assign mem_done = wb_ack;

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> wb_cyc && wb_stb);

  a_stb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we)
                          && (!wb_we || $stable(wb_dat_o)));

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu -f filelist.f -o tb_cpu \
  || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/tb_cpu 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qx "test passed" && exit 0 || exit 1

// File: sim/tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu import cpu_pkg::*; ();

  localparam int ADDR_W       = 12;
  localparam int MEM_WORDS    = 1 << ADDR_W;
  localparam int RESET_CYCLES = 10;
  localparam int HALT_WATCH   = 50;

  logic              clk = 1'b0;
  logic              rst_n;
  logic [15:0]       wb_dat_i = 16'h0000;
  logic              wb_ack = 1'b0;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [ADDR_W-1:0] wb_adr;
  logic [15:0]       wb_dat_o;
  logic [15:0]       out_data;
  logic              out_valid;
  logic              halted;

  logic [15:0]       image [0:MEM_WORDS-1]; // Program image, copied in during reset
  logic [15:0]       mem [0:MEM_WORDS-1];
  logic [15:0]       outs [$];
  logic [15:0]       exp_q [$];
  logic [15:0]       lfsr = 16'd76;
  logic              in_cycle = 1'b0;
  logic [1:0]        wait_left;
  logic [ADDR_W-1:0] hold_adr;
  logic              hold_we;
  logic [15:0]       hold_dat;
  int                pc_at;
  int                n_instr;
  int                hold_errs = 0;
  int                n_checks = 0;
  int                n_errors = 0;
  int                cycle_count = 0;
  int                cycle_limit = 0;

  cpu_top #(
    .ADDR_W (ADDR_W)
  ) u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_dat_i  (wb_dat_i),
    .wb_ack    (wb_ack),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_o  (wb_dat_o),
    .out_data  (out_data),
    .out_valid (out_valid),
    .halted    (halted)
  );

  always #10 clk = ~clk;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Memory slave, 0 to 3 wait states per cycle
  always @(posedge clk) begin
    if (rst_n && wb_cyc != wb_stb) begin
      hold_errs++;
      $display("Wishbone cyc and stb differ at address %h", wb_adr);
    end
    if (!rst_n) begin
      wb_ack   <= 1'b0;
      in_cycle = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] = image[i];
      end
    end else if (wb_cyc && wb_stb) begin
      if (!in_cycle) begin
        in_cycle     = 1'b1;
        hold_adr     = wb_adr;
        hold_we      = wb_we;
        hold_dat     = wb_dat_o;
        lfsr         = lfsr_step(lfsr);
        wait_left[0] = lfsr[0];
        lfsr         = lfsr_step(lfsr);
        wait_left[1] = lfsr[0];
      end else if (wb_adr != hold_adr || wb_we != hold_we
                   || (wb_we && wb_dat_o != hold_dat)) begin
        hold_errs++;
        $display("Wishbone request changed before ack at address %h", wb_adr);
      end
      if (wb_ack) begin
        wb_ack   <= 1'b0;
        in_cycle = 1'b0;
      end else if (wait_left == 2'd0) begin
        wb_ack <= 1'b1;
        if (wb_we) begin
          mem[wb_adr] = wb_dat_o;
        end else begin
          wb_dat_i <= mem[wb_adr];
        end
      end else begin
        wait_left = wait_left - 2'd1;
      end
    end else begin
      if (in_cycle) begin
        hold_errs++;
        $display("Wishbone cycle dropped before ack at address %h", hold_adr);
      end
      wb_ack   <= 1'b0;
      in_cycle = 1'b0;
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      outs.delete();
    end else if (out_valid) begin
      outs.push_back(out_data);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout, the CPU did not halt within %0d cycles", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  task automatic check(input string name, input logic [15:0] expected,
                       input logic [15:0] actual);
    n_checks++;
    if (expected !== actual) begin
      n_errors++;
      $display("Error in %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  function automatic logic [15:0] encode(input logic [3:0] op, input logic imm,
                                         input logic [2:0] dst, input logic [7:0] low);
    encode = {op, imm, dst, low};
  endfunction

  function automatic logic [7:0] reg_low(input logic ind, input logic [2:0] s);
    reg_low = {ind, s, 4'h0};
  endfunction

  function automatic logic [15:0] op_result(input logic [3:0] op, input logic [15:0] x,
                                            input logic [15:0] y);
    case (op)
      OP_ADD:  op_result = x + y;
      OP_SUB:  op_result = x - y;
      OP_AND:  op_result = x & y;
      OP_OR:   op_result = x | y;
      default: op_result = x ^ y;
    endcase
  endfunction

  function automatic logic [3:0] sub_flags(input logic [15:0] x, input logic [15:0] y);
    logic [16:0] d;
    d                  = {1'b0, x} - {1'b0, y};
    sub_flags          = 4'h0;
    sub_flags[FLAG_Z]  = (d[15:0] == 16'h0000);
    sub_flags[FLAG_C]  = d[16]; // Borrow
    sub_flags[FLAG_N]  = d[15];
    sub_flags[FLAG_V]  = (x[15] ^ y[15]) & (x[15] ^ d[15]);
  endfunction

  task automatic new_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      image[i] = 16'h0000;
    end
    pc_at   = 0;
    n_instr = 0;
    exp_q.delete();
  endtask

  task automatic emit(input logic [15:0] w);
    image[pc_at] = w;
    pc_at++;
    n_instr++;
  endtask

  task automatic emit_out(input logic ind, input logic [2:0] s);
    emit(encode(OP_SYS, SYS_OUT[3], SYS_OUT[2:0], reg_low(ind, s)));
  endtask

  task automatic emit_halt();
    emit(encode(OP_SYS, SYS_HLT[3], SYS_HLT[2:0], 8'h00));
  endtask

  task automatic run_program(input string name);
    int idle_cyc;
    cycle_limit += n_instr * 5 * 4 + RESET_CYCLES + HALT_WATCH + 4;
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    check({name, " reset state"}, 16'd0, {12'd0, halted, wb_cyc, wb_stb, out_valid});
    rst_n <= 1'b1;
    @(posedge clk);
    while (!halted) begin
      @(posedge clk);
    end
    idle_cyc = 0;
    repeat (HALT_WATCH) begin
      @(posedge clk);
      if (wb_cyc) begin
        idle_cyc++;
      end
    end
    check({name, " bus after halt"}, 16'd0, 16'(idle_cyc));
    check({name, " wishbone hold"}, 16'd0, 16'(hold_errs));
    check({name, " output count"}, 16'(exp_q.size()), 16'(outs.size()));
    for (int i = 0; i < exp_q.size() && i < outs.size(); i++) begin
      check(name, exp_q[i], outs[i]);
    end
  endtask

  task automatic ld_and_out();
    new_program();
    emit(encode(OP_LD, 1'b1, 3'd1, 8'h3C));
    emit(encode(OP_LD, 1'b1, 3'd2, 8'hA5));
    emit(encode(OP_LD, 1'b0, 3'd3, reg_low(1'b0, 3'd1))); // r3 = r1
    emit(encode(OP_LD, 1'b1, 3'd4, 8'hFF));
    emit(encode(OP_LD, 1'b1, 3'd5, 8'h00));
    emit(encode(OP_LD, 1'b0, 3'd6, reg_low(1'b0, 3'd2)));
    for (int r = 1; r <= 6; r++) begin
      emit_out(1'b0, 3'(r));
    end
    emit_halt();
    exp_q.push_back(16'h003C);
    exp_q.push_back(16'h00A5);
    exp_q.push_back(16'h003C);
    exp_q.push_back(16'h00FF);
    exp_q.push_back(16'h0000);
    exp_q.push_back(16'h00A5);
    run_program("ld_and_out");
  endtask

  task automatic alu_forms();
    logic [3:0]  ops [0:4];
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] c;
    logic [15:0] k;
    ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    a   = 16'hC3A5;
    b   = 16'h5A0F;
    c   = 16'h8001;
    k   = 16'h006B;
    new_program();
    image[12'h0E0] = a;
    image[12'h0E1] = b;
    image[12'h0E2] = c;
    emit(encode(OP_LD, 1'b1, 3'd6, 8'hE0));
    emit(encode(OP_LD, 1'b1, 3'd3, 8'hE1));
    emit(encode(OP_LD, 1'b0, 3'd2, reg_low(1'b1, 3'd3)));
    emit(encode(OP_LD, 1'b1, 3'd4, 8'hE2));
    foreach (ops[i]) begin
      emit(encode(OP_LD, 1'b0, 3'd1, reg_low(1'b1, 3'd6)));
      emit(encode(ops[i], 1'b1, 3'd1, k[7:0]));
      emit_out(1'b0, 3'd1);
      emit(encode(OP_LD, 1'b0, 3'd1, reg_low(1'b1, 3'd6)));
      emit(encode(ops[i], 1'b0, 3'd1, reg_low(1'b0, 3'd2)));
      emit_out(1'b0, 3'd1);
      emit(encode(OP_LD, 1'b0, 3'd1, reg_low(1'b1, 3'd6)));
      emit(encode(ops[i], 1'b0, 3'd1, reg_low(1'b1, 3'd4)));
      emit_out(1'b0, 3'd1);
      exp_q.push_back(op_result(ops[i], a, k));
      exp_q.push_back(op_result(ops[i], a, b));
      exp_q.push_back(op_result(ops[i], a, c));
    end
    emit_halt();
    run_program("alu_forms");
  endtask

  task automatic store_and_load();
    new_program();
    image[12'h0E8] = 16'hBEEF;
    emit(encode(OP_LD, 1'b1, 3'd4, 8'hE8));
    emit(encode(OP_LD, 1'b0, 3'd2, reg_low(1'b1, 3'd4)));
    emit(encode(OP_LD, 1'b1, 3'd1, 8'hF0));
    emit(encode(OP_ST, 1'b0, 3'd1, reg_low(1'b0, 3'd2))); // mem[r1] = r2
    emit(encode(OP_LD, 1'b0, 3'd3, reg_low(1'b1, 3'd1)));
    emit_out(1'b0, 3'd3);
    emit_out(1'b1, 3'd1);
    emit_halt();
    exp_q.push_back(16'hBEEF);
    exp_q.push_back(16'hBEEF);
    run_program("store_and_load");
    check("store_and_load memory", 16'hBEEF, mem[12'h0F0]);
  endtask

  task automatic compare_branch();
    logic [15:0] lhs [0:2];
    logic [15:0] rhs [0:2];
    logic [3:0]  f;
    logic [2:0]  cc;
    logic        taken;
    lhs = '{16'h1234, 16'h0005, 16'h8000}; // Equal, less than, overflow
    rhs = '{16'h1234, 16'h7000, 16'h0001};
    new_program();
    emit(encode(OP_LD, 1'b1, 3'd4, 8'h11));
    emit(encode(OP_LD, 1'b1, 3'd5, 8'h22));
    for (int p = 0; p < 3; p++) begin
      image[12'h0F0 + 2 * p] = lhs[p];
      image[12'h0F1 + 2 * p] = rhs[p];
      f = sub_flags(lhs[p], rhs[p]);
      for (int c = 0; c < 8; c++) begin
        cc    = 3'(c);
        taken = cc[0] ? ~f[cc[2:1]] : f[cc[2:1]];
        emit(encode(OP_LD, 1'b1, 3'd6, 8'(8'hF0 + 2 * p)));
        emit(encode(OP_LD, 1'b0, 3'd1, reg_low(1'b1, 3'd6)));
        emit(encode(OP_LD, 1'b1, 3'd6, 8'(8'hF1 + 2 * p)));
        emit(encode(OP_CMP, 1'b0, 3'd1, reg_low(1'b1, 3'd6)));
        emit(encode(OP_BR, 1'b1, cc, 8'(pc_at + 2))); // Skips the next OUT
        emit_out(1'b0, 3'd4);
        emit_out(1'b0, 3'd5);
        if (!taken) begin
          exp_q.push_back(16'h0011);
        end
        exp_q.push_back(16'h0022);
      end
    end
    emit_halt();
    run_program("compare_branch");
  endtask

  task automatic jump_skip();
    logic [11:0] t;
    int          seen;
    new_program();
    emit(encode(OP_LD, 1'b1, 3'd1, 8'h77));
    emit(encode(OP_LD, 1'b1, 3'd2, 8'h99));
    emit_out(1'b0, 3'd1);
    t = 12'(pc_at + 2);
    emit(encode(OP_JMP, t[11], t[10:8], t[7:0]));
    emit_out(1'b0, 3'd2); // Never reached
    emit_out(1'b0, 3'd1);
    emit_halt();
    exp_q.push_back(16'h0077);
    exp_q.push_back(16'h0077);
    run_program("jump_skip");
    seen = 0;
    foreach (outs[i]) begin
      if (outs[i] == 16'h0099) begin
        seen++;
      end
    end
    check("jump_skip skipped value", 16'd0, 16'(seen));
  endtask

  initial begin
    rst_n <= 1'b0;
    ld_and_out();
    alu_forms();
    store_and_load();
    compare_branch();
    jump_skip();
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
